// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_top -f src.f -o tb_sim
./obj_dir/tb_sim | tee sim.log
if grep -q "TESTS PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// ==== source/addr_matcher.sv ====
// Address matcher classifying received header addresses by priority
`default_nettype none

module addr_matcher
  import i3c_cfg_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  addr_cfg_t       addr_cfg_i,
  input  wire logic       hdr_valid_i,
  input  wire logic [6:0] hdr_addr_i,
  output logic            match_valid_o,
  output match_t          match_o
);

  match_t match_d;
  match_t match_q;
  logic   valid_q;

  always_comb begin
    match_d.hit  = 1'b1;
    match_d.kind = MATCH_NONE;
    if (hdr_addr_i == BROADCAST_ADDR) begin
      match_d.kind = MATCH_BROADCAST;
    end else if (addr_cfg_i.dyn_valid && hdr_addr_i == addr_cfg_i.dyn_addr) begin
      match_d.kind = MATCH_DYNAMIC;
    end else if (addr_cfg_i.sta_valid && !addr_cfg_i.dyn_valid &&
                 hdr_addr_i == addr_cfg_i.sta_addr) begin
      match_d.kind = MATCH_STATIC;  // Static only until DAA assigns one
    end else if (addr_cfg_i.virt_dyn_valid && hdr_addr_i == addr_cfg_i.virt_dyn_addr) begin
      match_d.kind = MATCH_VIRT_DYNAMIC;
    end else if (addr_cfg_i.virt_sta_valid && !addr_cfg_i.virt_dyn_valid &&
                 hdr_addr_i == addr_cfg_i.virt_sta_addr) begin
      match_d.kind = MATCH_VIRT_STATIC;
    end else begin
      match_d.hit = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) valid_q <= 1'b0;
    else valid_q <= hdr_valid_i;
  end

  always_ff @(posedge clk_i) begin
    if (hdr_valid_i) match_q <= match_d;
  end

  assign match_valid_o = valid_q;
  assign match_o       = match_q;

endmodule

`default_nettype wire

// ==== source/bus_idle_timer.sv ====
// Bus idle timer raising bus free, idle and available levels from bus-high time
`default_nettype none

module bus_idle_timer
  import i3c_cfg_pkg::*;
(
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  input  timing_cfg_t timing_i,
  input  wire logic  bus_high_i,
  output logic       bus_free_o,
  output logic       bus_idle_o,
  output logic       bus_avail_o
);

  logic [TIMER_W-1:0] count_q;

  // Restarts on any low bus, sticks at all ones
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (!bus_high_i) begin
      count_q <= '0;
    end else if (count_q != '1) begin
      count_q <= count_q + 1'b1;
    end
  end

  // A zero threshold disables its level
  assign bus_free_o  = (timing_i.t_free != '0) && (count_q >= timing_i.t_free);
  assign bus_idle_o  = (timing_i.t_idle != '0) && (count_q >= timing_i.t_idle);
  assign bus_avail_o = (timing_i.t_aval != '0) && (count_q >= timing_i.t_aval);

endmodule

`default_nettype wire

// ==== source/ccc_responder.sv ====
// CCC responder answering direct GET CCCs and ENTDAA and accepting SETMWL and SETMRL
`default_nettype none

module ccc_responder
  import i3c_cfg_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  input  dev_id_t          dev_id_i,
  input  wire logic        ccc_valid_i,
  input  wire logic [7:0]  ccc_code_i,
  input  wire logic [15:0] ccc_data_i,
  output logic             ccc_resp_valid_o,
  output ccc_resp_t        ccc_resp_o,
  output logic             set_mwl_o,
  output logic             set_mrl_o,
  output logic [15:0]      set_len_o
);

  ccc_resp_t   resp_d;
  ccc_resp_t   resp_q;
  logic        valid_q;
  logic        set_mwl_q;
  logic        set_mrl_q;
  logic [15:0] set_len_q;

  // Bytes are left-justified so the first one on the bus sits at [63:56]
  always_comb begin
    resp_d = '0;
    case (ccc_code_i)
      CCC_GETMWL:    resp_d = '{data: {dev_id_i.mwl, 48'h0}, count: 4'd2, nack: 1'b0};
      CCC_GETMRL:    resp_d = '{data: {dev_id_i.mrl, 48'h0}, count: 4'd2, nack: 1'b0};
      CCC_GETPID:    resp_d = '{data: {dev_id_i.pid, 16'h0}, count: 4'd6, nack: 1'b0};
      CCC_GETBCR:    resp_d = '{data: {dev_id_i.bcr, 56'h0}, count: 4'd1, nack: 1'b0};
      CCC_GETDCR:    resp_d = '{data: {dev_id_i.dcr, 56'h0}, count: 4'd1, nack: 1'b0};
      CCC_GETSTATUS: resp_d = '{data: {dev_id_i.status, 48'h0}, count: 4'd2, nack: 1'b0};
      CCC_ENTDAA: begin
        resp_d.data  = {dev_id_i.pid, dev_id_i.bcr, dev_id_i.dcr};  // Unique DAA response
        resp_d.count = 4'd8;
      end
      CCC_SETMWL, CCC_SETMRL: resp_d = '0;  // Accepted, nothing to return
      default: resp_d.nack = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= 1'b0;
      set_mwl_q <= 1'b0;
      set_mrl_q <= 1'b0;
    end else begin
      valid_q   <= ccc_valid_i;
      set_mwl_q <= ccc_valid_i && (ccc_code_i == CCC_SETMWL);
      set_mrl_q <= ccc_valid_i && (ccc_code_i == CCC_SETMRL);
    end
  end

  always_ff @(posedge clk_i) begin
    if (ccc_valid_i) begin
      resp_q    <= resp_d;
      set_len_q <= ccc_data_i;
    end
  end

  assign ccc_resp_valid_o = valid_q;
  assign ccc_resp_o       = resp_q;
  assign set_mwl_o        = set_mwl_q;
  assign set_mrl_o        = set_mrl_q;
  assign set_len_o        = set_len_q;

endmodule

`default_nettype wire

// ==== source/csr_regfile.sv ====
// CSR file holding the writable target configuration registers as one packed struct
`default_nettype none

module csr_regfile
  import i3c_cfg_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  input  wire logic        csr_we_i,
  input  wire logic [7:0]  csr_addr_i,
  input  wire logic [31:0] csr_wdata_i,
  output csr_t             csr_o
);

  csr_t csr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      csr_q <= '0;
    end else if (csr_we_i) begin
      case (csr_addr_i)
        CSR_CONTROL: begin
          csr_q.mode           <= target_mode_e'(csr_wdata_i[1:0]);
          csr_q.target_xact_en <= csr_wdata_i[4];
          csr_q.ibi_en         <= csr_wdata_i[8];
          csr_q.ibi_retry_num  <= csr_wdata_i[11:9];
        end
        CSR_DEVICE_ADDR: begin
          csr_q.sta_addr       <= csr_wdata_i[6:0];
          csr_q.sta_addr_valid <= csr_wdata_i[15];
          csr_q.dyn_addr       <= csr_wdata_i[22:16];
          csr_q.dyn_addr_valid <= csr_wdata_i[31];
        end
        CSR_VIRT_ADDR: begin
          csr_q.virt_sta_addr       <= csr_wdata_i[6:0];
          csr_q.virt_sta_addr_valid <= csr_wdata_i[15];
          csr_q.virt_dyn_addr       <= csr_wdata_i[22:16];
          csr_q.virt_dyn_addr_valid <= csr_wdata_i[31];
        end
        CSR_PID_LO: csr_q.pid_lo <= csr_wdata_i[15:0];
        CSR_PID_HI: csr_q.pid_hi <= csr_wdata_i[30:0];
        CSR_DEVICE_CHAR: begin
          csr_q.dcr <= csr_wdata_i[7:0];
          csr_q.bcr <= csr_wdata_i[15:8];
        end
        CSR_T_FREE: csr_q.t_free <= csr_wdata_i[TIMER_W-1:0];
        CSR_T_IDLE: csr_q.t_idle <= csr_wdata_i[TIMER_W-1:0];
        CSR_T_AVAL: csr_q.t_aval <= csr_wdata_i[TIMER_W-1:0];
        default: ;  // Unmapped offsets drop the write
      endcase
    end
  end

  assign csr_o = csr_q;

endmodule

`default_nettype wire

// ==== source/i3c_cfg_pkg.sv ====
// I3C target configuration package with CSR map, CCC codes and shared types
`default_nettype none

package i3c_cfg_pkg;

  localparam int unsigned TIMER_W = 20;  // Covers 1 ms at 1 GHz

  // CSR byte offsets
  localparam logic [7:0] CSR_CONTROL     = 8'h00;  // [1:0] mode, [4] xact en, [8] ibi en, [11:9] retry
  localparam logic [7:0] CSR_DEVICE_ADDR = 8'h04;  // [6:0] static, [15] valid, [22:16] dyn, [31] valid
  localparam logic [7:0] CSR_VIRT_ADDR   = 8'h08;  // Same layout as CSR_DEVICE_ADDR
  localparam logic [7:0] CSR_PID_LO      = 8'h0C;  // [15:0]
  localparam logic [7:0] CSR_PID_HI      = 8'h10;  // [30:0]
  localparam logic [7:0] CSR_DEVICE_CHAR = 8'h14;  // [7:0] dcr, [15:8] bcr
  localparam logic [7:0] CSR_T_FREE      = 8'h18;
  localparam logic [7:0] CSR_T_IDLE      = 8'h1C;
  localparam logic [7:0] CSR_T_AVAL      = 8'h20;

  localparam logic [7:0] CCC_ENTDAA    = 8'h07;
  localparam logic [7:0] CCC_SETMWL    = 8'h89;
  localparam logic [7:0] CCC_SETMRL    = 8'h8A;
  localparam logic [7:0] CCC_GETMWL    = 8'h8B;
  localparam logic [7:0] CCC_GETMRL    = 8'h8C;
  localparam logic [7:0] CCC_GETPID    = 8'h8D;
  localparam logic [7:0] CCC_GETBCR    = 8'h8E;
  localparam logic [7:0] CCC_GETDCR    = 8'h8F;
  localparam logic [7:0] CCC_GETSTATUS = 8'h90;

  localparam logic [6:0] BROADCAST_ADDR = 7'h7E;
  localparam logic [6:0] HOT_JOIN_ADDR  = 7'h02;

  localparam logic [15:0] MWL_RESET = 16'd256;
  localparam logic [15:0] MRL_RESET = 16'd256;

  typedef enum logic [1:0] {
    MODE_DISABLED     = 2'b00,
    MODE_ACM_INIT     = 2'b01,
    MODE_SCM_RUNNING  = 2'b10,
    MODE_SCM_HOT_JOIN = 2'b11
  } target_mode_e;

  typedef enum logic [2:0] {
    MATCH_NONE, MATCH_BROADCAST, MATCH_DYNAMIC, MATCH_STATIC, MATCH_VIRT_DYNAMIC, MATCH_VIRT_STATIC
  } match_kind_e;

  typedef struct packed {
    target_mode_e       mode;
    logic               target_xact_en;
    logic               ibi_en;
    logic [2:0]         ibi_retry_num;
    logic [6:0]         sta_addr;
    logic               sta_addr_valid;
    logic [6:0]         dyn_addr;
    logic               dyn_addr_valid;
    logic [6:0]         virt_sta_addr;
    logic               virt_sta_addr_valid;
    logic [6:0]         virt_dyn_addr;
    logic               virt_dyn_addr_valid;
    logic [15:0]        pid_lo;
    logic [30:0]        pid_hi;
    logic [7:0]         bcr;
    logic [7:0]         dcr;
    logic [TIMER_W-1:0] t_free;
    logic [TIMER_W-1:0] t_idle;
    logic [TIMER_W-1:0] t_aval;
  } csr_t;

  typedef struct packed {
    logic [6:0] sta_addr;
    logic       sta_valid;
    logic [6:0] dyn_addr;
    logic       dyn_valid;
    logic [6:0] virt_sta_addr;
    logic       virt_sta_valid;
    logic [6:0] virt_dyn_addr;
    logic       virt_dyn_valid;
    logic [6:0] ibi_addr;
    logic       ibi_valid;
  } addr_cfg_t;

  typedef struct packed {
    logic [47:0] pid;
    logic [7:0]  bcr;
    logic [7:0]  dcr;
    logic [15:0] mwl;
    logic [15:0] mrl;
    logic [15:0] status;  // GETSTATUS format 1 word
  } dev_id_t;

  typedef struct packed {
    logic [TIMER_W-1:0] t_free;
    logic [TIMER_W-1:0] t_idle;
    logic [TIMER_W-1:0] t_aval;
  } timing_cfg_t;

  typedef struct packed {
    logic        hit;
    match_kind_e kind;
  } match_t;

  typedef struct packed {
    logic [63:0] data;   // Left-justified, first byte in [63:56]
    logic [3:0]  count;
    logic        nack;
  } ccc_resp_t;

endpackage

`default_nettype wire

// ==== source/i3c_target_cfg_top.sv ====
// I3C target configuration top connecting CSRs, config decode, matcher, CCC responder and timer
`default_nettype none

module i3c_target_cfg_top
  import i3c_cfg_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  input  wire logic        csr_we_i,
  input  wire logic [7:0]  csr_addr_i,
  input  wire logic [31:0] csr_wdata_i,
  input  wire logic [5:0]  status_i,
  input  wire logic        hdr_valid_i,
  input  wire logic [6:0]  hdr_addr_i,
  input  wire logic        ccc_valid_i,
  input  wire logic [7:0]  ccc_code_i,
  input  wire logic [15:0] ccc_data_i,
  input  wire logic        bus_high_i,

  output logic             phy_en_o,
  output logic [1:0]       phy_mux_select_o,
  output logic             i3c_active_en_o,
  output logic             i3c_standby_en_o,
  output logic             ibi_enable_o,
  output logic [2:0]       ibi_retry_num_o,
  output logic [6:0]       hot_join_addr_o,
  output logic [6:0]       ibi_addr_o,
  output logic             ibi_addr_valid_o,
  output logic             match_valid_o,
  output match_t           match_o,
  output logic             ccc_resp_valid_o,
  output ccc_resp_t        ccc_resp_o,
  output logic             bus_free_o,
  output logic             bus_idle_o,
  output logic             bus_avail_o
);

  csr_t        csr;
  addr_cfg_t   addr_cfg;
  dev_id_t     dev_id;
  timing_cfg_t timing;
  logic        set_mwl;
  logic        set_mrl;
  logic [15:0] set_len;

  csr_regfile u_csr_regfile (
    .clk_i, .rst_ni, .csr_we_i, .csr_addr_i, .csr_wdata_i,
    .csr_o (csr)
  );

  target_config u_target_config (
    .clk_i, .rst_ni,
    .csr_i      (csr),
    .status_i,
    .set_mwl_i  (set_mwl),
    .set_mrl_i  (set_mrl),
    .set_len_i  (set_len),
    .addr_cfg_o (addr_cfg),
    .dev_id_o   (dev_id),
    .timing_o   (timing),
    .phy_en_o, .phy_mux_select_o, .i3c_active_en_o, .i3c_standby_en_o,
    .ibi_enable_o, .ibi_retry_num_o, .hot_join_addr_o
  );

  assign ibi_addr_o       = addr_cfg.ibi_addr;
  assign ibi_addr_valid_o = addr_cfg.ibi_valid;

  addr_matcher u_addr_matcher (
    .clk_i, .rst_ni,
    .addr_cfg_i (addr_cfg),
    .hdr_valid_i, .hdr_addr_i, .match_valid_o, .match_o
  );

  ccc_responder u_ccc_responder (
    .clk_i, .rst_ni,
    .dev_id_i  (dev_id),
    .ccc_valid_i, .ccc_code_i, .ccc_data_i, .ccc_resp_valid_o, .ccc_resp_o,
    .set_mwl_o (set_mwl),
    .set_mrl_o (set_mrl),
    .set_len_o (set_len)
  );

  bus_idle_timer u_bus_idle_timer (
    .clk_i, .rst_ni,
    .timing_i (timing),
    .bus_high_i, .bus_free_o, .bus_idle_o, .bus_avail_o
  );

endmodule

`default_nettype wire

// ==== source/target_config.sv ====
// Target configuration block decoding CSRs into mode, address, identity, timing and IBI setup
`default_nettype none

module target_config
  import i3c_cfg_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  input  csr_t             csr_i,
  input  wire logic [5:0]  status_i,   // [5:4] error flags, [3:0] pending interrupts
  input  wire logic        set_mwl_i,
  input  wire logic        set_mrl_i,
  input  wire logic [15:0] set_len_i,

  output addr_cfg_t        addr_cfg_o,
  output dev_id_t          dev_id_o,
  output timing_cfg_t      timing_o,
  output logic             phy_en_o,
  output logic [1:0]       phy_mux_select_o,
  output logic             i3c_active_en_o,
  output logic             i3c_standby_en_o,
  output logic             ibi_enable_o,
  output logic [2:0]       ibi_retry_num_o,
  output logic [6:0]       hot_join_addr_o
);

  logic [15:0] mwl_q;
  logic [15:0] mrl_q;
  logic        protocol_error;

  // Mode decode
  assign i3c_active_en_o  = (csr_i.mode == MODE_ACM_INIT) || (csr_i.mode == MODE_SCM_HOT_JOIN);
  assign i3c_standby_en_o = (csr_i.mode == MODE_SCM_RUNNING);

  assign phy_en_o            = 1'b1;
  assign phy_mux_select_o[0] = i3c_active_en_o | i3c_standby_en_o;
  assign phy_mux_select_o[1] = i3c_standby_en_o;  // No I2C standby in target-only build

  // Addresses
  assign addr_cfg_o.sta_addr       = csr_i.sta_addr;
  assign addr_cfg_o.sta_valid      = csr_i.sta_addr_valid;
  assign addr_cfg_o.dyn_addr       = csr_i.dyn_addr;
  assign addr_cfg_o.dyn_valid      = csr_i.dyn_addr_valid;
  assign addr_cfg_o.virt_sta_addr  = csr_i.virt_sta_addr;
  assign addr_cfg_o.virt_sta_valid = csr_i.virt_sta_addr_valid;
  assign addr_cfg_o.virt_dyn_addr  = csr_i.virt_dyn_addr;
  assign addr_cfg_o.virt_dyn_valid = csr_i.virt_dyn_addr_valid;
  assign addr_cfg_o.ibi_addr  = csr_i.dyn_addr_valid ? csr_i.dyn_addr : csr_i.sta_addr;
  assign addr_cfg_o.ibi_valid = csr_i.dyn_addr_valid | csr_i.sta_addr_valid;

  assign hot_join_addr_o = HOT_JOIN_ADDR;

  // Either error flag counts as a protocol error
  assign protocol_error = |status_i[5:4];

  // Identity and lengths
  assign dev_id_o.pid    = {csr_i.pid_hi, 1'b0, csr_i.pid_lo};
  assign dev_id_o.bcr    = csr_i.bcr;
  assign dev_id_o.dcr    = csr_i.dcr;
  assign dev_id_o.mwl    = mwl_q;
  assign dev_id_o.mrl    = mrl_q;
  assign dev_id_o.status = {8'h00, 2'b11, protocol_error, 1'b0, status_i[3:0]};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mwl_q <= MWL_RESET;
      mrl_q <= MRL_RESET;
    end else begin
      if (set_mwl_i) mwl_q <= set_len_i;
      if (set_mrl_i) mrl_q <= set_len_i;
    end
  end

  assign timing_o.t_free = csr_i.t_free;
  assign timing_o.t_idle = csr_i.t_idle;
  assign timing_o.t_aval = csr_i.t_aval;

  // IBI only when target transactions are on
  assign ibi_enable_o    = csr_i.ibi_en & csr_i.target_xact_en;
  assign ibi_retry_num_o = csr_i.ibi_retry_num;

endmodule

`default_nettype wire

// ==== src.f ====
source/i3c_cfg_pkg.sv
source/csr_regfile.sv
source/target_config.sv
source/addr_matcher.sv
source/ccc_responder.sv
source/bus_idle_timer.sv
source/i3c_target_cfg_top.sv
verif/tb_clk_gen.sv
verif/tb_properties.sv
verif/tb_top.sv

// ==== verif/tb_clk_gen.sv ====
// Testbench clock generator with a 4 ns period
`default_nettype none

module tb_clk_gen (
  output logic clk_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial clk_o = 1'b0;
  always #2 clk_o = ~clk_o;  // Half period

endmodule

`default_nettype wire

// ==== verif/tb_properties.sv ====
// Assertions on response latency, nack format and bus timer levels of the target config top
`default_nettype none

module tb_properties
  import i3c_cfg_pkg::*;
(
  input wire logic clk_i,
  input wire logic rst_ni,
  input wire logic hdr_valid_i,
  input wire logic match_valid_o,
  input wire logic ccc_valid_i,
  input wire logic ccc_resp_valid_o,
  input ccc_resp_t ccc_resp_o,
  input wire logic bus_high_i,
  input wire logic bus_free_o,
  input wire logic bus_idle_o,
  input wire logic bus_avail_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // One result per header pulse, one cycle later
  assert property (@(posedge clk_i) disable iff (!rst_ni) match_valid_o == $past(hdr_valid_i))
    else $error("match_valid_o is not one cycle after hdr_valid_i");

  assert property (@(posedge clk_i) disable iff (!rst_ni) ccc_resp_valid_o == $past(ccc_valid_i))
    else $error("ccc_resp_valid_o is not one cycle after ccc_valid_i");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   (ccc_resp_valid_o && ccc_resp_o.nack) |-> ccc_resp_o.count == 4'd0)
    else $error("CCC nack with a nonzero byte count");

  // Levels drop one cycle after the bus goes low
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   !bus_high_i |=> !(bus_free_o || bus_idle_o || bus_avail_o))
    else $error("Bus timer level set while bus_high_i is low");

endmodule

bind i3c_target_cfg_top tb_properties props_i (
  .clk_i, .rst_ni, .hdr_valid_i, .match_valid_o, .ccc_valid_i, .ccc_resp_valid_o,
  .ccc_resp_o, .bus_high_i, .bus_free_o, .bus_idle_o, .bus_avail_o
);

`default_nettype wire

// ==== verif/tb_top.sv ====
// Testbench top running directed tests on the I3C target configuration block
`default_nettype none

module tb_top
  import i3c_cfg_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  // Cycle budgets per test, summed by the watchdog
  localparam int RESET_CYCLES   = 16;
  localparam int BUDGET_RESET   = 40;
  localparam int BUDGET_MODE    = 100;
  localparam int BUDGET_MATCH   = 120;
  localparam int BUDGET_IDENT   = 60;
  localparam int BUDGET_LENGTH  = 60;
  localparam int BUDGET_TIMER   = 80;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + BUDGET_RESET + BUDGET_MODE + BUDGET_MATCH +
                                   BUDGET_IDENT + BUDGET_LENGTH + BUDGET_TIMER;

  logic        clk_i;
  logic        rst_ni;
  logic        csr_we_i;
  logic [7:0]  csr_addr_i;
  logic [31:0] csr_wdata_i;
  logic [5:0]  status_i;
  logic        hdr_valid_i;
  logic [6:0]  hdr_addr_i;
  logic        ccc_valid_i;
  logic [7:0]  ccc_code_i;
  logic [15:0] ccc_data_i;
  logic        bus_high_i;
  logic        phy_en_o;
  logic [1:0]  phy_mux_select_o;
  logic        i3c_active_en_o;
  logic        i3c_standby_en_o;
  logic        ibi_enable_o;
  logic [2:0]  ibi_retry_num_o;
  logic [6:0]  hot_join_addr_o;
  logic [6:0]  ibi_addr_o;
  logic        ibi_addr_valid_o;
  logic        match_valid_o;
  match_t      match_o;
  logic        ccc_resp_valid_o;
  ccc_resp_t   ccc_resp_o;
  logic        bus_free_o;
  logic        bus_idle_o;
  logic        bus_avail_o;

  int n_errors = 0;
  int n_checks = 0;
  int n_tests  = 0;
  int test_start_errors = 0;
  logic [15:0] lfsr_q = 16'd54710;

  tb_clk_gen clk_gen_i (.clk_o(clk_i));

  i3c_target_cfg_top dut_i (.*);

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], lfsr_step()};
    return v;
  endfunction

  function automatic ccc_resp_t make_resp(input logic [63:0] data, input logic [3:0] count,
                                          input logic nack);
    ccc_resp_t r;
    r.data  = data;
    r.count = count;
    r.nack  = nack;
    return r;
  endfunction

  // Register layout of CSR_DEVICE_ADDR and CSR_VIRT_ADDR
  function automatic logic [31:0] addr_word(input logic [6:0] sta, input logic sta_v,
                                            input logic [6:0] dyn, input logic dyn_v);
    return {dyn_v, 8'h00, dyn, sta_v, 8'h00, sta};
  endfunction

  // Priority order: broadcast, dynamic, static, virtual dynamic, virtual static
  function automatic match_t expect_match(input addr_cfg_t c, input logic [6:0] a);
    match_t m;
    m.hit  = 1'b1;
    m.kind = MATCH_NONE;
    if (a == 7'h7E) m.kind = MATCH_BROADCAST;
    else if (c.dyn_valid && a == c.dyn_addr) m.kind = MATCH_DYNAMIC;
    else if (c.sta_valid && !c.dyn_valid && a == c.sta_addr) m.kind = MATCH_STATIC;
    else if (c.virt_dyn_valid && a == c.virt_dyn_addr) m.kind = MATCH_VIRT_DYNAMIC;
    else if (c.virt_sta_valid && !c.virt_dyn_valid && a == c.virt_sta_addr)
      m.kind = MATCH_VIRT_STATIC;
    else m.hit = 1'b0;
    return m;
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("** Error @ %0t: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("** Error @ %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_match(input string name, input match_t got, input match_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("** Error @ %0t: %s = hit %b kind %0d, expected hit %b kind %0d",
               $time, name, got.hit, got.kind, exp.hit, exp.kind);
    end
  endtask

  task automatic check_resp(input string name, input ccc_resp_t got, input ccc_resp_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("** Error @ %0t: %s = %h/%0d/%b, expected %h/%0d/%b", $time, name,
               got.data, got.count, got.nack, exp.data, exp.count, exp.nack);
    end
  endtask

  task automatic check_levels(input logic free, input logic idle, input logic aval);
    check_bit("bus_free_o", bus_free_o, free);
    check_bit("bus_idle_o", bus_idle_o, idle);
    check_bit("bus_avail_o", bus_avail_o, aval);
  endtask

  // Ends on the falling edge after the write has landed
  task automatic write_csr(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk_i);
    csr_we_i    <= 1'b1;
    csr_addr_i  <= addr;
    csr_wdata_i <= data;
    @(posedge clk_i);
    csr_we_i <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic send_ccc(input string name, input logic [7:0] code, input logic [15:0] data,
                          input ccc_resp_t exp);
    @(posedge clk_i);
    ccc_valid_i <= 1'b1;
    ccc_code_i  <= code;
    ccc_data_i  <= data;
    @(posedge clk_i);
    ccc_valid_i <= 1'b0;
    @(negedge clk_i);
    check_bit("ccc_resp_valid_o", ccc_resp_valid_o, 1'b1);
    check_resp(name, ccc_resp_o, exp);
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = n_errors - test_start_errors;
    n_tests++;
    if (errs == 0) $display("[%0t] test %s: ok", $time, name);
    else $display("[%0t] test %s: %0d errors", $time, name, errs);
    test_start_errors = n_errors;
  endtask

  task automatic test_reset();
    check_bit("match_valid_o", match_valid_o, 1'b0);
    check_bit("ccc_resp_valid_o", ccc_resp_valid_o, 1'b0);
    check_bit("ibi_addr_valid_o", ibi_addr_valid_o, 1'b0);
    check_bit("i3c_active_en_o", i3c_active_en_o, 1'b0);
    check_bit("i3c_standby_en_o", i3c_standby_en_o, 1'b0);
    check_word("phy_mux_select_o", 32'(phy_mux_select_o), 32'd0);
    check_levels(1'b0, 1'b0, 1'b0);
    send_ccc("GETMWL", CCC_GETMWL, 16'h0, make_resp({16'd256, 48'h0}, 4'd2, 1'b0));
    send_ccc("GETMRL", CCC_GETMRL, 16'h0, make_resp({16'd256, 48'h0}, 4'd2, 1'b0));
  endtask

  task automatic test_mode();
    logic       active;
    logic       standby;
    logic       ibi;
    logic [2:0] retry;
    logic [6:0] sta;
    logic [6:0] dyn;
    logic       sta_v;
    logic       dyn_v;
    for (int m = 0; m < 4; m++) begin
      retry = 3'(rand_bits(3));
      ibi   = m[0];  // Same bit for IBI enable and target transactions
      write_csr(CSR_CONTROL, {20'h0, retry, ibi, 3'b000, ibi, 2'b00, 2'(m)});
      active  = (m == 1) || (m == 3);
      standby = (m == 2);
      check_bit("i3c_active_en_o", i3c_active_en_o, active);
      check_bit("i3c_standby_en_o", i3c_standby_en_o, standby);
      check_word("phy_mux_select_o", 32'(phy_mux_select_o), 32'({standby, active | standby}));
      check_bit("phy_en_o", phy_en_o, 1'b1);
      check_bit("ibi_enable_o", ibi_enable_o, ibi);
      check_word("ibi_retry_num_o", 32'(ibi_retry_num_o), 32'(retry));
      check_word("hot_join_addr_o", 32'(hot_join_addr_o), 32'h02);
    end
    sta = 7'(rand_bits(7));
    dyn = 7'(rand_bits(7));
    for (int k = 0; k < 4; k++) begin
      sta_v = k[0];
      dyn_v = k[1];
      write_csr(CSR_DEVICE_ADDR, addr_word(sta, sta_v, dyn, dyn_v));
      check_bit("ibi_addr_valid_o", ibi_addr_valid_o, sta_v | dyn_v);
      if (sta_v | dyn_v) check_word("ibi_addr_o", 32'(ibi_addr_o), 32'(dyn_v ? dyn : sta));
    end
  endtask

  task automatic test_match();
    addr_cfg_t  cfg;
    logic [6:0] addrs[$];
    for (int r = 0; r < 2; r++) begin
      cfg = '0;
      cfg.sta_addr       = 7'(rand_bits(7));
      cfg.dyn_addr       = 7'(rand_bits(7));
      cfg.virt_sta_addr  = 7'(rand_bits(7));
      cfg.virt_dyn_addr  = 7'(rand_bits(7));
      cfg.sta_valid      = 1'b1;
      cfg.dyn_valid      = (r == 1);
      cfg.virt_sta_valid = 1'b1;
      cfg.virt_dyn_valid = (r == 0);
      write_csr(CSR_DEVICE_ADDR, addr_word(cfg.sta_addr, cfg.sta_valid,
                                           cfg.dyn_addr, cfg.dyn_valid));
      write_csr(CSR_VIRT_ADDR, addr_word(cfg.virt_sta_addr, cfg.virt_sta_valid,
                                         cfg.virt_dyn_addr, cfg.virt_dyn_valid));
      addrs.delete();
      addrs.push_back(7'h7E);
      addrs.push_back(cfg.sta_addr);
      addrs.push_back(cfg.dyn_addr);
      addrs.push_back(cfg.virt_sta_addr);
      addrs.push_back(cfg.virt_dyn_addr);
      for (int i = 0; i < 8; i++) addrs.push_back(7'(rand_bits(7)));
      // Back-to-back headers, each result checked one cycle after its pulse
      for (int i = 0; i <= addrs.size(); i++) begin
        @(posedge clk_i);
        hdr_valid_i <= (i < addrs.size());
        if (i < addrs.size()) hdr_addr_i <= addrs[i];
        @(negedge clk_i);
        if (i > 0) begin
          check_bit("match_valid_o", match_valid_o, 1'b1);
          check_match("match_o", match_o, expect_match(cfg, addrs[i-1]));
        end
      end
    end
  endtask

  task automatic test_identity();
    logic [15:0] pid_lo;
    logic [30:0] pid_hi;
    logic [7:0]  bcr;
    logic [7:0]  dcr;
    logic [5:0]  st;
    logic [47:0] pid;
    pid_lo = 16'(rand_bits(16));
    pid_hi = 31'(rand_bits(31));
    bcr    = 8'(rand_bits(8));
    dcr    = 8'(rand_bits(8));
    st     = 6'(rand_bits(6));
    pid    = {pid_hi, 1'b0, pid_lo};
    write_csr(CSR_PID_LO, 32'(pid_lo));
    write_csr(CSR_PID_HI, 32'(pid_hi));
    write_csr(CSR_DEVICE_CHAR, {16'h0, bcr, dcr});
    @(posedge clk_i);
    status_i <= st;
    send_ccc("GETPID", CCC_GETPID, 16'h0, make_resp({pid, 16'h0}, 4'd6, 1'b0));
    send_ccc("GETBCR", CCC_GETBCR, 16'h0, make_resp({bcr, 56'h0}, 4'd1, 1'b0));
    send_ccc("GETDCR", CCC_GETDCR, 16'h0, make_resp({dcr, 56'h0}, 4'd1, 1'b0));
    send_ccc("GETSTATUS", CCC_GETSTATUS, 16'h0,
             make_resp({8'h00, 2'b11, |st[5:4], 1'b0, st[3:0], 48'h0}, 4'd2, 1'b0));
    send_ccc("ENTDAA", CCC_ENTDAA, 16'h0, make_resp({pid, bcr, dcr}, 4'd8, 1'b0));
    send_ccc("unknown CCC", 8'h22, 16'h0, make_resp(64'h0, 4'd0, 1'b1));
  endtask

  task automatic test_lengths();
    logic [15:0] mwl;
    logic [15:0] mrl;
    for (int r = 0; r < 2; r++) begin
      mwl = 16'(rand_bits(16));
      mrl = 16'(rand_bits(16));
      send_ccc("SETMWL", CCC_SETMWL, mwl, make_resp(64'h0, 4'd0, 1'b0));
      send_ccc("SETMRL", CCC_SETMRL, mrl, make_resp(64'h0, 4'd0, 1'b0));
      send_ccc("GETMWL", CCC_GETMWL, 16'h0, make_resp({mwl, 48'h0}, 4'd2, 1'b0));
      send_ccc("GETMRL", CCC_GETMRL, 16'h0, make_resp({mrl, 48'h0}, 4'd2, 1'b0));
    end
  endtask

  task automatic test_timer();
    int t_free;
    int t_idle;
    int t_aval;
    t_free = 1 + int'(rand_bits(4));  // 1 to 16 cycles
    t_idle = 1 + int'(rand_bits(4));
    t_aval = 1 + int'(rand_bits(4));
    write_csr(CSR_T_FREE, 32'(t_free));
    write_csr(CSR_T_IDLE, 32'(t_idle));
    write_csr(CSR_T_AVAL, 32'(t_aval));
    @(posedge clk_i);
    bus_high_i <= 1'b1;
    for (int c = 0; c <= 20; c++) begin
      @(negedge clk_i);
      check_levels(c >= t_free, c >= t_idle, c >= t_aval);
    end
    @(posedge clk_i);
    bus_high_i <= 1'b0;
    @(negedge clk_i);
    check_levels(1'b1, 1'b1, 1'b1);  // Count clears on the next edge
    @(negedge clk_i);
    check_levels(1'b0, 1'b0, 1'b0);
  endtask

  initial begin
    rst_ni      <= 1'b0;
    csr_we_i    <= 1'b0;
    csr_addr_i  <= '0;
    csr_wdata_i <= '0;
    status_i    <= '0;
    hdr_valid_i <= 1'b0;
    hdr_addr_i  <= '0;
    ccc_valid_i <= 1'b0;
    ccc_code_i  <= '0;
    ccc_data_i  <= '0;
    bus_high_i  <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    test_reset();
    finish_test("reset values");
    test_mode();
    finish_test("mode and IBI decode");
    test_match();
    finish_test("address matching");
    test_identity();
    finish_test("identity CCCs");
    test_lengths();
    finish_test("length setting");
    test_timer();
    finish_test("bus timer");
    $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
